// ==== hdl/radio_io_params.svh ====
// radio i/o widths, spi word length and sclk divider
`ifndef RADIO_IO_PARAMS_SVH
`define RADIO_IO_PARAMS_SVH

// converter buses
`define ADC_W 12 // per adc channel
`define DAC_W 14 // shared i/q dac bus

// spi master
`define SPI_W 16 // bits per transfer
`define SPI_DIV 2 // clk_fpga cycles per sclk half period
`define NUM_SPI_SLV 4 // db tx, db rx, codec, clock gen

// host register port
`define REG_AW 2 // four registers

`endif

// ==== hdl/radio_io_pkg.sv ====
// radio i/o shared types: sample words, spi request and fsm states
`default_nettype none

`include "radio_io_params.svh"

package radio_io_pkg;

   ////////////////////////////////////////////////////////////
   // plain vectors
   ////////////////////////////////////////////////////////////
   typedef logic [`ADC_W-1:0] adc_word_t; // one adc sample
   typedef logic [`DAC_W-1:0] dac_word_t; // one dac sample
   typedef logic [`SPI_W-1:0] spi_word_t; // one spi transfer
   typedef logic [`REG_AW-1:0] reg_addr_t;
   typedef logic [15:0] reg_data_t; // host data word

   // slave numbering, also the sen/sclk/mosi bit index
   typedef enum logic [1:0] {
      spi_db_tx = 2'd0,
      spi_db_rx = 2'd1,
      spi_codec = 2'd2,
      spi_cgen = 2'd3
   } spi_sel_t;

   ////////////////////////////////////////////////////////////
   // bundles
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      adc_word_t i;
      adc_word_t q;
   } rx_sample_t;

   typedef struct packed {
      dac_word_t i;
      dac_word_t q;
   } tx_sample_t;

   typedef struct packed {
      spi_sel_t sel; // target slave
      spi_word_t word; // word to shift out
   } spi_req_t;

   // spi shift engine
   typedef enum logic [1:0] {
      spi_idle,
      spi_low, // sclk low, mosi set up
      spi_high, // sclk high
      spi_done // one cycle, response valid
   } spi_state_t;

endpackage

`default_nettype wire

// ==== hdl/host_ctrl_regs.sv ====
// host register file: run bits, spi select, transfer start, response capture
`timescale 1ns/1ps
`default_nettype none

`include "radio_io_params.svh"

module host_ctrl_regs
   import radio_io_pkg::*;
(
   input wire logic clk_fpga,
   input wire logic rst_n,
   // host strobes
   input wire logic wr_stb,
   input wire logic rd_stb,
   input wire reg_addr_t reg_addr,
   input wire reg_data_t wr_data,
   output reg_data_t rd_data,
   output logic has_resp, // pending spi response
   // spi master side
   input wire logic spi_busy,
   input wire logic spi_done,
   input wire spi_word_t spi_resp,
   output logic spi_start,
   output spi_req_t spi_req,
   // sample path enables
   output logic rx_run,
   output logic tx_run
);

   localparam reg_addr_t ADDR_RUN = 2'd0;
   localparam reg_addr_t ADDR_SEL = 2'd1;
   localparam reg_addr_t ADDR_SPI = 2'd2; // write starts, read gives busy
   localparam reg_addr_t ADDR_RESP = 2'd3;

   spi_sel_t sel_q; // current slave select
   spi_word_t resp_q; // last response word

   // start goes out in the write cycle, so busy is up by the next read
   assign spi_start = wr_stb && (reg_addr == ADDR_SPI) && !spi_busy;
   assign spi_req.sel = sel_q;
   assign spi_req.word = spi_word_t'(wr_data);

   ////////////////////////////////////////////////////////////
   // write decode
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_fpga or negedge rst_n) begin
      if (!rst_n) begin
         rx_run <= 1'b0;
         tx_run <= 1'b0;
         sel_q <= spi_db_tx;
      end else if (wr_stb) begin
         if (reg_addr == ADDR_RUN) begin
            rx_run <= wr_data[0];
            tx_run <= wr_data[1];
         end
         if (reg_addr == ADDR_SEL) begin
            sel_q <= spi_sel_t'(wr_data[1:0]);
         end
      end
   end

   // response word, only loaded at end of transfer
   always_ff @(posedge clk_fpga) begin
      if (spi_done) begin
         resp_q <= spi_resp;
      end
   end

   // has_resp follows spi_done by one cycle, a new done beats the clearing read
   always_ff @(posedge clk_fpga or negedge rst_n) begin
      if (!rst_n) begin
         has_resp <= 1'b0;
      end else if (spi_done) begin
         has_resp <= 1'b1;
      end else if (rd_stb && (reg_addr == ADDR_RESP)) begin
         has_resp <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // read mux, registered
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_fpga or negedge rst_n) begin
      if (!rst_n) begin
         rd_data <= '0;
      end else if (rd_stb) begin
         case (reg_addr)
            ADDR_RUN: rd_data <= reg_data_t'({tx_run, rx_run});
            ADDR_SEL: rd_data <= reg_data_t'(sel_q);
            ADDR_SPI: rd_data <= reg_data_t'(spi_busy);
            default: rd_data <= reg_data_t'(resp_q); // response
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hdl/spi_master.sv ====
// mode-0 spi master with one shift engine routed to the selected peripheral slave
`timescale 1ns/1ps
`default_nettype none

`include "radio_io_params.svh"

module spi_master
   import radio_io_pkg::*;
(
   input wire logic clk_fpga,
   input wire logic rst_n,
   input wire logic spi_start, // ignored unless idle
   input wire spi_req_t spi_req,
   output logic spi_busy,
   output logic spi_done,
   output spi_word_t spi_resp,
   // one line per slave
   output logic [`NUM_SPI_SLV-1:0] sclk,
   output logic [`NUM_SPI_SLV-1:0] mosi,
   output logic [`NUM_SPI_SLV-1:0] sen, // active low
   input wire logic [`NUM_SPI_SLV-1:0] miso
);

   localparam int DIV_W = (`SPI_DIV > 1) ? $clog2(`SPI_DIV) : 1;
   localparam int BIT_W = $clog2(`SPI_W);

   spi_state_t state;
   spi_sel_t sel_q; // slave latched at start
   logic [DIV_W-1:0] div_cnt; // half period counter
   logic [BIT_W-1:0] bit_cnt; // bits done
   spi_word_t tx_shift;
   spi_word_t rx_shift;
   logic div_end;
   logic active; // sen asserted
   logic miso_sel;
   logic [`NUM_SPI_SLV-1:0] slv_hit;

   assign div_end = (div_cnt == DIV_W'(`SPI_DIV - 1));
   assign active = (state == spi_low) || (state == spi_high);

   ////////////////////////////////////////////////////////////
   // state machine
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_fpga or negedge rst_n) begin
      if (!rst_n) begin
         state <= spi_idle;
         sel_q <= spi_db_tx;
         div_cnt <= '0;
         bit_cnt <= '0;
      end else begin
         case (state)
            spi_idle: begin
               if (spi_start) begin
                  state <= spi_low; // sen drops next cycle
                  sel_q <= spi_req.sel;
                  div_cnt <= '0;
                  bit_cnt <= '0;
               end
            end
            spi_low: begin
               div_cnt <= div_end ? '0 : div_cnt + 1'b1;
               if (div_end) begin
                  state <= spi_high; // rising sclk
               end
            end
            spi_high: begin
               div_cnt <= div_end ? '0 : div_cnt + 1'b1;
               if (div_end) begin
                  if (bit_cnt == BIT_W'(`SPI_W - 1)) begin
                     state <= radio_io_pkg::spi_done; // release sen after the last bit
                  end else begin
                     state <= spi_low;
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            default: state <= spi_idle; // spi_done lasts one cycle
         endcase
      end
   end

   // data shifters
   always_ff @(posedge clk_fpga) begin
      if ((state == spi_idle) && spi_start) begin
         tx_shift <= spi_req.word;
      end else if ((state == spi_high) && div_end) begin
         tx_shift <= {tx_shift[`SPI_W-2:0], 1'b0}; // next bit on falling sclk
      end
      if ((state == spi_low) && div_end) begin
         rx_shift <= {rx_shift[`SPI_W-2:0], miso_sel}; // sample on sclk rise
      end
   end

   assign spi_busy = (state != spi_idle);
   assign spi_done = (state == radio_io_pkg::spi_done);
   assign spi_resp = rx_shift;

   ////////////////////////////////////////////////////////////
   // per slave routing
   ////////////////////////////////////////////////////////////
   for (genvar k = 0; k < `NUM_SPI_SLV; k++) begin : g_slv
      assign slv_hit[k] = active && (sel_q == spi_sel_t'(k));
   end

   assign sen = ~slv_hit;
   assign sclk = slv_hit & {`NUM_SPI_SLV{state == spi_high}}; // others stay 0
   assign mosi = slv_hit & {`NUM_SPI_SLV{tx_shift[`SPI_W-1]}};
   assign miso_sel = |(~sen & miso); // only the selected slave gets through

endmodule

`default_nettype wire

// ==== hdl/adc_capture.sv ====
// adc capture: registers the two inverted converter buses as one rx sample
`timescale 1ns/1ps
`default_nettype none

`include "radio_io_params.svh"

module adc_capture
   import radio_io_pkg::*;
(
   input wire logic clk_fpga,
   input wire logic rst_n,
   input wire logic rx_run,
   input wire adc_word_t adc_a, // DA, i channel
   input wire adc_word_t adc_b, // DB, q channel
   output rx_sample_t rx_sample,
   output logic rx_strobe
);

   // board wires the converter outputs inverted, undo it here
   always_ff @(posedge clk_fpga) begin
      rx_sample.i <= ~adc_a;
      rx_sample.q <= ~adc_b;
   end

   // strobe lines up with the sample taken while running
   always_ff @(posedge clk_fpga or negedge rst_n) begin
      if (!rst_n) begin
         rx_strobe <= 1'b0;
      end else begin
         rx_strobe <= rx_run;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/dac_interleave.sv ====
// dac interleave: sends i then q of each tx pair on one bus, sync marks q
`timescale 1ns/1ps
`default_nettype none

`include "radio_io_params.svh"

module dac_interleave
   import radio_io_pkg::*;
(
   input wire logic clk_fpga,
   input wire logic rst_n,
   input wire logic tx_run,
   input wire tx_sample_t tx_sample,
   output dac_word_t dac_data,
   output logic dac_sync // high on q
);

   logic phase; // 0 takes a new pair
   dac_word_t delay_q; // q half of the pair

   // q waits one cycle behind its i
   always_ff @(posedge clk_fpga) begin
      if (tx_run && !phase) begin
         delay_q <= tx_sample.q;
      end
   end

   ////////////////////////////////////////////////////////////
   // half rate interleave
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_fpga or negedge rst_n) begin
      if (!rst_n) begin
         phase <= 1'b0;
         dac_data <= '0;
         dac_sync <= 1'b0;
      end else if (!tx_run) begin
         phase <= 1'b0; // bus idles at zero
         dac_data <= '0;
         dac_sync <= 1'b0;
      end else if (!phase) begin
         phase <= 1'b1;
         dac_data <= tx_sample.i; // i straight through
         dac_sync <= 1'b0;
      end else begin
         phase <= 1'b0;
         dac_data <= delay_q;
         dac_sync <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/radio_io_top.sv ====
// radio i/o top: host registers, shared spi master and the two sample paths
`timescale 1ns/1ps
`default_nettype none

`include "radio_io_params.svh"

module radio_io_top
   import radio_io_pkg::*;
(
   input wire logic clk_fpga,
   input wire logic rst_n,
   // host port
   input wire logic wr_stb,
   input wire logic rd_stb,
   input wire reg_addr_t reg_addr,
   input wire reg_data_t wr_data,
   output reg_data_t rd_data,
   output logic has_resp,
   // spi slaves, index by spi_sel_t
   output logic [`NUM_SPI_SLV-1:0] sclk,
   output logic [`NUM_SPI_SLV-1:0] mosi,
   output logic [`NUM_SPI_SLV-1:0] sen,
   input wire logic [`NUM_SPI_SLV-1:0] miso,
   // converters
   input wire adc_word_t adc_a,
   input wire adc_word_t adc_b,
   output rx_sample_t rx_sample,
   output logic rx_strobe,
   input wire tx_sample_t tx_sample,
   output dac_word_t dac_data,
   output logic dac_sync
);

   logic spi_start;
   spi_req_t spi_req;
   logic spi_busy;
   logic spi_done;
   spi_word_t spi_resp;
   logic rx_run;
   logic tx_run;

   ////////////////////////////////////////////////////////////
   // control
   ////////////////////////////////////////////////////////////
   host_ctrl_regs u_regs (
      .clk_fpga(clk_fpga), .rst_n(rst_n),
      .wr_stb(wr_stb), .rd_stb(rd_stb), .reg_addr(reg_addr),
      .wr_data(wr_data), .rd_data(rd_data), .has_resp(has_resp),
      .spi_busy(spi_busy), .spi_done(spi_done), .spi_resp(spi_resp),
      .spi_start(spi_start), .spi_req(spi_req),
      .rx_run(rx_run), .tx_run(tx_run)
   );

   spi_master u_spi (
      .clk_fpga(clk_fpga), .rst_n(rst_n),
      .spi_start(spi_start), .spi_req(spi_req),
      .spi_busy(spi_busy), .spi_done(spi_done), .spi_resp(spi_resp),
      .sclk(sclk), .mosi(mosi), .sen(sen), .miso(miso)
   );

   ////////////////////////////////////////////////////////////
   // sample paths
   ////////////////////////////////////////////////////////////
   adc_capture u_adc (
      .clk_fpga(clk_fpga), .rst_n(rst_n), .rx_run(rx_run),
      .adc_a(adc_a), .adc_b(adc_b),
      .rx_sample(rx_sample), .rx_strobe(rx_strobe)
   );

   dac_interleave u_dac (
      .clk_fpga(clk_fpga), .rst_n(rst_n), .tx_run(tx_run),
      .tx_sample(tx_sample), .dac_data(dac_data), .dac_sync(dac_sync)
   );

endmodule

`default_nettype wire

// ==== sim/radio_io_assertions.sv ====
// radio i/o bus assertions: spi select routing, response flag and dac sync
`timescale 1ns/1ps
`default_nettype none

`include "radio_io_params.svh"

module radio_io_assertions (
   input wire logic clk_fpga,
   input wire logic rst_n,
   input wire logic [`NUM_SPI_SLV-1:0] sen, // active low
   input wire logic [`NUM_SPI_SLV-1:0] sclk,
   input wire logic spi_done,
   input wire logic has_resp,
   input wire logic tx_run,
   input wire logic dac_sync
);

   // at most one slave enabled at a time
   a_one_sen: assert property (@(posedge clk_fpga) disable iff (!rst_n)
      $onehot0(~sen)) else $error("more than one sen low");

   // sclk only toggles on the enabled slave
   a_sclk_sel: assert property (@(posedge clk_fpga) disable iff (!rst_n)
      (sclk & sen) == '0) else $error("sclk high on an unselected slave");

   a_resp_flag: assert property (@(posedge clk_fpga) disable iff (!rst_n)
      spi_done |=> has_resp) else $error("has_resp did not follow spi_done");

   // two running edges in a row, so sync must flip
   a_sync_alt: assert property (@(posedge clk_fpga) disable iff (!rst_n)
      tx_run && $past(tx_run) |=> dac_sync != $past(dac_sync))
      else $error("dac_sync did not alternate while tx_run high");

endmodule

bind radio_io_top radio_io_assertions u_asrt (
   .clk_fpga(clk_fpga), .rst_n(rst_n), .sen(sen), .sclk(sclk),
   .spi_done(spi_done), .has_resp(has_resp), .tx_run(tx_run), .dac_sync(dac_sync)
);

`default_nettype wire

// ==== sim/radio_io_tb.sv ====
// radio i/o testbench with host register traffic, spi slave models and sample path checks
`timescale 1ns/1ps
`default_nettype none

`include "radio_io_params.svh"

module radio_io_tb
   import radio_io_pkg::*;
();

   localparam int CLK_HALF = 5; // 10 ns period
   localparam int NUM_REG = 8; // register write/read rounds
   localparam int NUM_XFER = 20;
   localparam int XFER_CYC = 1 + 2 * `SPI_DIV * `SPI_W; // 65 cycles
   localparam int SAMPLE_CYC = 100;
   localparam int LIMIT_CYC = 2 * (NUM_REG * 4 + NUM_XFER * (XFER_CYC + 10) + SAMPLE_CYC + 20);

   logic clk_fpga;
   logic rst_n;
   logic wr_stb;
   logic rd_stb;
   reg_addr_t reg_addr;
   reg_data_t wr_data;
   reg_data_t rd_data;
   logic has_resp;
   logic [`NUM_SPI_SLV-1:0] sclk;
   logic [`NUM_SPI_SLV-1:0] mosi;
   logic [`NUM_SPI_SLV-1:0] sen;
   logic [`NUM_SPI_SLV-1:0] miso;
   adc_word_t adc_a;
   adc_word_t adc_b;
   rx_sample_t rx_sample;
   logic rx_strobe;
   tx_sample_t tx_sample;
   dac_word_t dac_data;
   logic dac_sync;

   // reference model state
   logic m_rx_run;
   logic m_tx_run;
   logic m_phase; // 0 takes a new pair
   dac_word_t m_pair_q;
   spi_sel_t act_sel; // slave in a transfer
   logic act_valid;
   logic slave_out; // bit the selected slave drives on miso
   logic [31:0] rnd_state;

   radio_io_top uut (
      .clk_fpga(clk_fpga), .rst_n(rst_n), .wr_stb(wr_stb), .rd_stb(rd_stb),
      .reg_addr(reg_addr), .wr_data(wr_data), .rd_data(rd_data), .has_resp(has_resp),
      .sclk(sclk), .mosi(mosi), .sen(sen), .miso(miso),
      .adc_a(adc_a), .adc_b(adc_b), .rx_sample(rx_sample), .rx_strobe(rx_strobe),
      .tx_sample(tx_sample), .dac_data(dac_data), .dac_sync(dac_sync)
   );

   initial clk_fpga = 1'b0;
   always #CLK_HALF clk_fpga = ~clk_fpga;

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////
   function automatic logic [31:0] xorshift32();
      rnd_state = rnd_state ^ (rnd_state << 13);
      rnd_state = rnd_state ^ (rnd_state >> 17);
      rnd_state = rnd_state ^ (rnd_state << 5);
      return rnd_state;
   endfunction

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_reg(input reg_data_t got, input reg_data_t exp, input string name);
      if (got !== exp)
         stop_with_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
   endtask

   task automatic check_rx(input rx_sample_t got, input rx_sample_t exp, input string name);
      if (got !== exp)
         stop_with_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
   endtask

   task automatic check_dac(input dac_word_t got, input dac_word_t exp, input string name);
      if (got !== exp)
         stop_with_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
   endtask

   task automatic check_spi(input spi_word_t got, input spi_word_t exp, input string name);
      if (got !== exp)
         stop_with_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
   endtask

   task automatic check_flag(input logic got, input logic exp, input string name);
      if (got !== exp)
         stop_with_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
   endtask

   ////////////////////////////////////////////////////////////
   // one clock of sample path checks followed by fresh inputs
   ////////////////////////////////////////////////////////////
   task automatic step();
      adc_word_t a_in;
      adc_word_t b_in;
      tx_sample_t t_in;
      logic w_stb;
      reg_addr_t w_addr;
      reg_data_t w_data;
      rx_sample_t exp_rx;
      dac_word_t exp_dac;
      logic exp_sync;
      logic [31:0] r;
      a_in = adc_a; // inputs seen at the coming edge
      b_in = adc_b;
      t_in = tx_sample;
      w_stb = wr_stb;
      w_addr = reg_addr;
      w_data = wr_data;
      @(posedge clk_fpga);
      #1;
      exp_rx.i = ~a_in; // board inverts the converter bits
      exp_rx.q = ~b_in;
      check_rx(rx_sample, exp_rx, "rx_sample");
      check_flag(rx_strobe, m_rx_run, "rx_strobe");
      if (!m_tx_run) begin
         exp_dac = '0; // idle bus
         exp_sync = 1'b0;
         m_phase = 1'b0;
      end else if (!m_phase) begin
         exp_dac = t_in.i; // i of a new pair
         exp_sync = 1'b0;
         m_pair_q = t_in.q;
         m_phase = 1'b1;
      end else begin
         exp_dac = m_pair_q; // q of the same pair
         exp_sync = 1'b1;
         m_phase = 1'b0;
      end
      check_dac(dac_data, exp_dac, "dac_data");
      check_flag(dac_sync, exp_sync, "dac_sync");
      if (w_stb && (w_addr == 2'd0)) begin
         m_rx_run = w_data[0];
         m_tx_run = w_data[1];
      end
      r = xorshift32();
      adc_a = r[11:0];
      adc_b = r[23:12];
      r = xorshift32();
      tx_sample.i = r[13:0];
      tx_sample.q = r[27:14];
      r = xorshift32();
      miso = r[3:0]; // noise on idle slaves
      if (act_valid)
         miso[act_sel] = slave_out;
   endtask

   task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
      wr_stb = 1'b1;
      reg_addr = addr;
      wr_data = data;
      step();
      wr_stb = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
      rd_stb = 1'b1;
      reg_addr = addr;
      step();
      rd_stb = 1'b0;
      data = rd_data; // registered one cycle after rd_stb
   endtask

   // lines of every other slave must stay quiet
   task automatic check_isolation(input spi_sel_t sel);
      for (int k = 0; k < `NUM_SPI_SLV; k++) begin
         if (k != int'(sel) && (sclk[k] || mosi[k] || !sen[k]))
            stop_with_error($sformatf("slave %0d lines active while slave %0d selected",
               k, int'(sel)));
      end
   endtask

   ////////////////////////////////////////////////////////////
   // spi transfer with a behavioural slave
   ////////////////////////////////////////////////////////////
   task automatic spi_transfer(input spi_sel_t sel, input spi_word_t word);
      spi_word_t resp_word;
      spi_word_t out_sr;
      spi_word_t got_word;
      reg_data_t rd;
      logic prev_sen;
      logic prev_sclk;
      int wait_cyc;
      logic [31:0] r;
      write_reg(2'd1, reg_data_t'(sel));
      do begin
         read_reg(2'd2, rd); // busy poll
      end while (rd[0]);
      check_flag(has_resp, 1'b0, "has_resp");
      r = xorshift32();
      resp_word = r[15:0];
      out_sr = resp_word;
      got_word = '0;
      act_sel = sel;
      act_valid = 1'b1;
      slave_out = 1'b0;
      prev_sen = 1'b1;
      prev_sclk = 1'b0;
      wait_cyc = 0;
      write_reg(2'd2, reg_data_t'(word));
      while (!has_resp) begin
         check_isolation(sel);
         // next bit out at sen fall and at each falling sclk
         if (!sen[sel] && (prev_sen || (prev_sclk && !sclk[sel]))) begin
            slave_out = out_sr[`SPI_W-1];
            out_sr = {out_sr[`SPI_W-2:0], 1'b0};
            miso[sel] = slave_out;
         end
         if (sclk[sel] && !prev_sclk)
            got_word = {got_word[`SPI_W-2:0], mosi[sel]}; // rising edge
         prev_sen = sen[sel];
         prev_sclk = sclk[sel];
         wait_cyc++;
         if (wait_cyc > 2 * XFER_CYC)
            stop_with_error("has_resp did not rise after an spi transfer");
         if (wait_cyc == 1) begin
            read_reg(2'd2, rd); // busy while shifting
            check_reg(rd, 16'h0001, "rd_data busy");
         end else begin
            step();
         end
      end
      act_valid = 1'b0;
      check_spi(got_word, word, "slave mosi word");
      read_reg(2'd3, rd);
      check_spi(spi_word_t'(rd), resp_word, "rd_data response");
      check_flag(has_resp, 1'b0, "has_resp"); // cleared by the read
   endtask

   // watchdog sized from the test lengths
   initial begin
      repeat (LIMIT_CYC) @(posedge clk_fpga);
      stop_with_error("watchdog expired before the tests finished");
   end

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      logic [31:0] r;
      reg_data_t rd;
      rst_n = 1'b0;
      wr_stb = 1'b0;
      rd_stb = 1'b0;
      reg_addr = '0;
      wr_data = '0;
      miso = '0;
      adc_a = '0;
      adc_b = '0;
      tx_sample = '0;
      m_rx_run = 1'b0;
      m_tx_run = 1'b0;
      m_phase = 1'b0;
      m_pair_q = '0;
      act_sel = spi_db_tx;
      act_valid = 1'b0;
      slave_out = 1'b0;
      rnd_state = 32'hb2c0;
      repeat (4) @(posedge clk_fpga);
      #1;
      rst_n = 1'b1;
      if (sen !== '1 || sclk !== '0 || mosi !== '0 || has_resp !== 1'b0)
         stop_with_error("spi lines or has_resp not idle after reset");
      if (rx_strobe !== 1'b0 || dac_sync !== 1'b0)
         stop_with_error("sample path outputs not idle after reset");
      read_reg(2'd0, rd);
      check_reg(rd, '0, "rd_data run bits");
      read_reg(2'd1, rd);
      check_reg(rd, reg_data_t'(spi_db_tx), "rd_data select");

      // register writes then read back
      for (int n = 0; n < NUM_REG; n++) begin
         r = xorshift32();
         write_reg(2'd0, r[15:0]);
         write_reg(2'd1, r[31:16]);
         read_reg(2'd0, rd);
         check_reg(rd, {14'b0, r[1:0]}, "rd_data run bits");
         read_reg(2'd1, rd);
         check_reg(rd, {14'b0, r[17:16]}, "rd_data select");
      end

      // spi to random slaves
      for (int n = 0; n < NUM_XFER; n++) begin
         r = xorshift32();
         spi_transfer(spi_sel_t'(r[1:0]), r[31:16]);
      end

      // sample paths in each run combination
      write_reg(2'd0, 16'h0003);
      repeat (40) step();
      write_reg(2'd0, 16'h0001);
      repeat (20) step();
      write_reg(2'd0, 16'h0002);
      repeat (20) step();
      write_reg(2'd0, 16'h0000);
      repeat (10) step();

      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hdl
hdl/radio_io_pkg.sv
hdl/host_ctrl_regs.sv
hdl/spi_master.sv
hdl/adc_capture.sv
hdl/dac_interleave.sv
hdl/radio_io_top.sv
sim/radio_io_assertions.sv
sim/radio_io_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the radio i/o testbench with verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module radio_io_tb -Mdir obj_dir -f compile.f \
   && ./obj_dir/Vradio_io_tb > sim.log 2>&1 \
   || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
